//--- sim.f
hdl/dma_pkg.sv
hdl/xdma_pkg.sv
hdl/dma_if.sv
hdl/dma_req_queue.sv
hdl/dma_ctrl.sv
hdl/xdma_assign.sv
hdl/dma_bridge_top.sv
sim/tb_clk_gen.sv
sim/dma_bridge_assert.sv
sim/dma_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the DMA bridge testbench, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module dma_bridge_tb -f sim.f -o dma_bridge_sim \
  > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/dma_bridge_sim > sim.log 2>&1
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- sim/dma_bridge_tb.sv
////////////////////////////////////////////////////////////////////////////
// DMA bridge testbench
// table driven requester and engine models with in-order descriptor checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_bridge_tb;

  typedef struct packed {
    logic           ch;    // 0 reads on h2c, 1 writes on c2h
    dma_pkg::addr_t addr;
    dma_pkg::len_t  len;
    logic           last;
    int             pct;   // chance in percent that the engine is ready
    int             dly;   // cycles from descriptor take to its done
  } row_t;

  localparam int N_ROWS = 10;

  row_t rows [N_ROWS] = '{
    '{1'b0, 64'h0000_0001_0000_1000, 28'h000_0100, 1'b1, 100, 2},  // lone read and write
    '{1'b1, 64'h0000_0002_0000_2000, 28'h000_0200, 1'b1, 100, 2},
    '{1'b0, 64'h0000_0001_0000_3000, 28'h000_1000, 1'b0, 100, 24}, // slow dones hit the limit
    '{1'b0, 64'h0000_0001_0000_4000, 28'h000_1000, 1'b0, 100, 24},
    '{1'b0, 64'h0000_0001_0000_5000, 28'h000_0040, 1'b1, 100, 3},
    '{1'b1, 64'h0000_0002_0000_6000, 28'h00f_fff0, 1'b0, 40, 5},   // random ready, interleaved
    '{1'b0, 64'hffff_0000_dead_b000, 28'h000_0004, 1'b0, 40, 4},
    '{1'b1, 64'h0000_0002_0000_7000, 28'h000_0800, 1'b1, 60, 1},
    '{1'b0, 64'h0000_0001_0000_8000, 28'h000_0010, 1'b1, 50, 6},
    '{1'b1, 64'h8000_0000_0000_9000, 28'hfff_ffff, 1'b0, 50, 12}
  };

  logic              aclk, reset;
  logic              rd_req_valid, rd_req_last, rd_credit, rd_done;
  logic              wr_req_valid, wr_req_last, wr_credit, wr_done;
  dma_pkg::addr_t    rd_req_paddr, wr_req_paddr, h2c_addr, c2h_addr;
  dma_pkg::len_t     rd_req_len, wr_req_len, h2c_len, c2h_len;
  logic              h2c_valid, h2c_ready, c2h_valid, c2h_ready;
  xdma_pkg::ctl_t    h2c_ctl, c2h_ctl;
  xdma_pkg::status_t h2c_status, c2h_status;

  int            seed;             // $random state
  int            cyc;              // cycles since reset was released
  int            i;                // next table row to send
  int            exp_rows [2][$];  // rows sent and not yet taken by the engine
  int            due [2][$];       // done cycle of each descriptor in flight
  int            sent [2];         // credits spent per channel
  int            returned [2];     // credit pulses seen per channel
  dma_pkg::cnt_t queued [2];       // requests held inside the DUT queue
  dma_pkg::cnt_t inflight [2];     // descriptors taken and not yet done
  logic          took [2];         // descriptor taken in the previous cycle
  logic          done_exp [2];     // status done bit driven this cycle

  tb_clk_gen tb_clk_gen_i (.aclk (aclk), .reset (reset));
  dma_bridge_top dma_bridge_top_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_ctl(input string name, input xdma_pkg::ctl_t exp,
                           input xdma_pkg::ctl_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input dma_pkg::addr_t exp,
                            input dma_pkg::addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_len(input string name, input dma_pkg::len_t exp,
                           input dma_pkg::len_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_cnt(input string name, input dma_pkg::cnt_t exp,
                           input dma_pkg::cnt_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // requester, engine and monitor models
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_row(input int r);
    exp_rows[rows[r].ch].push_back(r);
    sent[rows[r].ch]++;  // one credit spent
    if (rows[r].ch) begin
      {wr_req_valid, wr_req_paddr, wr_req_len, wr_req_last} =
        {1'b1, rows[r].addr, rows[r].len, rows[r].last};
    end else begin
      {rd_req_valid, rd_req_paddr, rd_req_len, rd_req_last} =
        {1'b1, rows[r].addr, rows[r].len, rows[r].last};
    end
  endtask

  // ready follows the oldest pending row, done fires once its delay has run out
  task automatic engine_step(input int ch, output logic rdy, output xdma_pkg::status_t st);
    int pct;
    pct = (exp_rows[ch].size() != 0) ? rows[exp_rows[ch][0]].pct : 50;
    rdy = int'($unsigned($random(seed)) % 32'd100) < pct;
    st  = xdma_pkg::status_t'($random(seed));  // noise on the bits that carry no done
    st[xdma_pkg::STATUS_DONE_BIT] = 1'b0;
    if (due[ch].size() != 0 && due[ch][0] <= cyc) begin
      st[xdma_pkg::STATUS_DONE_BIT] = 1'b1;
      due[ch].delete(0);
    end
    done_exp[ch] = st[xdma_pkg::STATUS_DONE_BIT];
  endtask

  task automatic watch_channel(input int ch, input logic valid, input xdma_pkg::ctl_t ctl,
                               input dma_pkg::addr_t addr, input dma_pkg::len_t len,
                               input logic credit, input logic done, input logic req,
                               input logic rdy);
    string eng;
    string side;
    logic  exp_valid;
    int    r;
    eng  = (ch == 0) ? "h2c" : "c2h";
    side = (ch == 0) ? "rd" : "wr";
    // a queued head goes out only below the in-flight limit and with the engine ready
    exp_valid = (queued[ch] != '0) && rdy &&
                (inflight[ch] < dma_pkg::cnt_t'(dma_pkg::MAX_OUTSTANDING));
    check_flag({eng, "_valid"}, exp_valid, valid);
    check_flag({side, "_credit"}, took[ch], credit);
    check_flag({side, "_done"}, done_exp[ch], done);
    if (valid) begin
      if (exp_rows[ch].size() == 0) abort_run({eng, " took a descriptor never requested"});
      r = exp_rows[ch].pop_front();
      check_addr({eng, "_addr"}, rows[r].addr, addr);
      check_len({eng, "_len"}, rows[r].len, len);
      check_ctl({eng, "_ctl"}, rows[r].last ? 16'h0013 : 16'h0000, ctl);  // bits 0, 1 and 4
      due[ch].push_back(cyc + rows[r].dly);
    end
    if (credit) returned[ch]++;
    if (req) queued[ch] = queued[ch] + 3'd1;
    if (valid) queued[ch] = queued[ch] - 3'd1;
    if (valid && !done_exp[ch]) inflight[ch] = inflight[ch] + 3'd1;
    if (done_exp[ch] && !valid) inflight[ch] = inflight[ch] - 3'd1;
    took[ch] = valid;
  endtask

  initial begin
    {rd_req_valid, rd_req_paddr, rd_req_len, rd_req_last} = '0;
    {wr_req_valid, wr_req_paddr, wr_req_len, wr_req_last} = '0;
    {h2c_ready, h2c_status} = '0;
    {c2h_ready, c2h_status} = '0;
    seed = 32'h5ad6;
    cyc  = 0;
    i    = 0;
    for (int c = 0; c < 2; c++) begin
      sent[c]     = 0;
      returned[c] = 0;
      queued[c]   = '0;
      inflight[c] = '0;
      took[c]     = 1'b0;
      done_exp[c] = 1'b0;
    end
    @(negedge aclk);
    while (reset) @(negedge aclk);
    while (i < N_ROWS || exp_rows[0].size() + exp_rows[1].size() +
           due[0].size() + due[1].size() != 0) begin
      engine_step(0, h2c_ready, h2c_status);
      engine_step(1, c2h_ready, c2h_status);
      {rd_req_valid, wr_req_valid} = 2'b00;
      // send the next row only while its requester still holds a credit
      if (i < N_ROWS && sent[rows[i].ch] - returned[rows[i].ch] < dma_pkg::QUEUE_DEPTH) begin
        send_row(i);
        i++;
      end
      @(posedge aclk);
      watch_channel(0, h2c_valid, h2c_ctl, h2c_addr, h2c_len,
                    rd_credit, rd_done, rd_req_valid, h2c_ready);
      watch_channel(1, c2h_valid, c2h_ctl, c2h_addr, c2h_len,
                    wr_credit, wr_done, wr_req_valid, c2h_ready);
      cyc++;
      @(negedge aclk);
    end
    check_cnt("rd credits held", dma_pkg::cnt_t'(dma_pkg::QUEUE_DEPTH),
              dma_pkg::cnt_t'(dma_pkg::QUEUE_DEPTH - sent[0] + returned[0]));
    check_cnt("wr credits held", dma_pkg::cnt_t'(dma_pkg::QUEUE_DEPTH),
              dma_pkg::cnt_t'(dma_pkg::QUEUE_DEPTH - sent[1] + returned[1]));
    $display("Finished with no errors");
    $finish;
  end

  // forty cycles per row covers the slowest completions with room to spare
  initial begin
    repeat (N_ROWS * 40) @(posedge aclk);
    $display("timeout, the bridge stopped handing over descriptors or completions");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sim/dma_bridge_assert.sv
////////////////////////////////////////////////////////////////////////////
// DMA control checks
// in-flight limit, credit return and engine ready rules, bound into dma_ctrl
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_bridge_assert (
  input logic          aclk,
  input logic          reset,
  input dma_pkg::cnt_t rd_out,
  input dma_pkg::cnt_t wr_out,
  input logic          rd_credit,
  input logic          wr_credit,
  input logic          rd_ready,
  input logic          wr_ready
);

  assert property (@(posedge aclk) disable iff (reset)
    rd_out <= dma_pkg::cnt_t'(dma_pkg::MAX_OUTSTANDING))
    else $error("read descriptors in flight above the limit");
  assert property (@(posedge aclk) disable iff (reset)
    wr_out <= dma_pkg::cnt_t'(dma_pkg::MAX_OUTSTANDING))
    else $error("write descriptors in flight above the limit");

  // a rise of the in-flight count means a queue slot was freed and its credit is due now
  assert property (@(posedge aclk) disable iff (reset) rd_out > $past(rd_out) |-> rd_credit)
    else $error("read descriptor taken without a credit on the next cycle");
  assert property (@(posedge aclk) disable iff (reset) wr_out > $past(wr_out) |-> wr_credit)
    else $error("write descriptor taken without a credit on the next cycle");

  // no descriptor enters flight in a cycle where the engine is not ready
  assert property (@(posedge aclk) disable iff (reset) !rd_ready |=> rd_out <= $past(rd_out))
    else $error("read descriptor left while the engine was not ready");
  assert property (@(posedge aclk) disable iff (reset) !wr_ready |=> wr_out <= $past(wr_out))
    else $error("write descriptor left while the engine was not ready");

endmodule

bind dma_ctrl dma_bridge_assert dma_bridge_assert_i (
  .aclk      (aclk),
  .reset     (reset),
  .rd_out    (rd_out),
  .wr_out    (wr_out),
  .rd_credit (rd_credit),
  .wr_credit (wr_credit),
  .rd_ready  (rd_eng.ready),
  .wr_ready  (wr_eng.ready)
);

//--- sim/tb_clk_gen.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset
// 8 ns clock with reset held over the first three rising edges
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
  output logic aclk,
  output logic reset
);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;  // half of the 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge aclk);
    #1 reset = 1'b0;  // released just after the third edge so the DUT still samples it there
  end

endmodule

//--- hdl/dma_bridge_top.sv
////////////////////////////////////////////////////////////////////////////
// DMA descriptor bridge
// credited request queues in front of the XDMA descriptor bypass ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_bridge_top (
  input  logic              aclk,
  input  logic              reset,
  // read requester
  input  logic              rd_req_valid,
  input  dma_pkg::addr_t    rd_req_paddr,
  input  dma_pkg::len_t     rd_req_len,
  input  logic              rd_req_last,
  output logic              rd_credit,
  output logic              rd_done,
  // write requester
  input  logic              wr_req_valid,
  input  dma_pkg::addr_t    wr_req_paddr,
  input  dma_pkg::len_t     wr_req_len,
  input  logic              wr_req_last,
  output logic              wr_credit,
  output logic              wr_done,
  // host to card descriptor bypass
  output xdma_pkg::ctl_t    h2c_ctl,
  output dma_pkg::addr_t    h2c_addr,
  output dma_pkg::len_t     h2c_len,
  output logic              h2c_valid,
  input  logic              h2c_ready,
  input  xdma_pkg::status_t h2c_status,
  // card to host descriptor bypass
  output xdma_pkg::ctl_t    c2h_ctl,
  output dma_pkg::addr_t    c2h_addr,
  output dma_pkg::len_t     c2h_len,
  output logic              c2h_valid,
  input  logic              c2h_ready,
  input  xdma_pkg::status_t c2h_status
);

  dma_if rd_q ();    // read queue head into control
  dma_if wr_q ();    // write queue head into control
  dma_if rd_eng ();  // gated read requests into the formatter
  dma_if wr_eng ();  // gated write requests into the formatter

  ////////////////////////////////////////////////////////////////////////////
  // request queues
  ////////////////////////////////////////////////////////////////////////////

  dma_req_queue rd_queue (
    .aclk      (aclk),
    .reset     (reset),
    .req_valid (rd_req_valid),
    .req_paddr (rd_req_paddr),
    .req_len   (rd_req_len),
    .req_last  (rd_req_last),
    .q         (rd_q)
  );

  dma_req_queue wr_queue (
    .aclk      (aclk),
    .reset     (reset),
    .req_valid (wr_req_valid),
    .req_paddr (wr_req_paddr),
    .req_len   (wr_req_len),
    .req_last  (wr_req_last),
    .q         (wr_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // flow control and engine formatting
  ////////////////////////////////////////////////////////////////////////////

  dma_ctrl dma_ctrl_i (
    .aclk      (aclk),
    .reset     (reset),
    .rd_q      (rd_q),
    .wr_q      (wr_q),
    .rd_eng    (rd_eng),
    .wr_eng    (wr_eng),
    .rd_credit (rd_credit),
    .wr_credit (wr_credit),
    .rd_done   (rd_done),
    .wr_done   (wr_done)
  );

  xdma_assign xdma_assign_i (
    .rd         (rd_eng),
    .wr         (wr_eng),
    .h2c_ctl    (h2c_ctl),
    .h2c_addr   (h2c_addr),
    .h2c_len    (h2c_len),
    .h2c_valid  (h2c_valid),
    .h2c_ready  (h2c_ready),
    .h2c_status (h2c_status),
    .c2h_ctl    (c2h_ctl),
    .c2h_addr   (c2h_addr),
    .c2h_len    (c2h_len),
    .c2h_valid  (c2h_valid),
    .c2h_ready  (c2h_ready),
    .c2h_status (c2h_status)
  );

endmodule

//--- hdl/xdma_assign.sv
////////////////////////////////////////////////////////////////////////////
// XDMA descriptor formatter
// maps DMA requests onto the engine bypass ports and decodes completions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module xdma_assign (
  dma_if.s                  rd,
  dma_if.s                  wr,
  output xdma_pkg::ctl_t    h2c_ctl,
  output dma_pkg::addr_t    h2c_addr,
  output dma_pkg::len_t     h2c_len,
  output logic              h2c_valid,
  input  logic              h2c_ready,
  input  xdma_pkg::status_t h2c_status,
  output xdma_pkg::ctl_t    c2h_ctl,
  output dma_pkg::addr_t    c2h_addr,
  output dma_pkg::len_t     c2h_len,
  output logic              c2h_valid,
  input  logic              c2h_ready,
  input  xdma_pkg::status_t c2h_status
);

  // stop, completed and eop all follow the last flag and nothing else is set
  function automatic xdma_pkg::ctl_t build_ctl(logic last);
    xdma_pkg::ctl_t ctl;
    ctl = '0;
    ctl[xdma_pkg::CTL_STOP_BIT]      = last;
    ctl[xdma_pkg::CTL_COMPLETED_BIT] = last;
    ctl[xdma_pkg::CTL_EOP_BIT]       = last;
    return ctl;
  endfunction

  // read channel goes out on h2c
  assign h2c_ctl   = build_ctl(rd.last);
  assign h2c_addr  = rd.paddr;
  assign h2c_len   = rd.len;
  assign h2c_valid = rd.valid & h2c_ready;  // the engine only sees valid when it can take it
  assign rd.ready  = h2c_ready;
  assign rd.done   = h2c_status[xdma_pkg::STATUS_DONE_BIT];  // other status bits are dropped

  // write channel goes out on c2h
  assign c2h_ctl   = build_ctl(wr.last);
  assign c2h_addr  = wr.paddr;
  assign c2h_len   = wr.len;
  assign c2h_valid = wr.valid & c2h_ready;
  assign wr.ready  = c2h_ready;
  assign wr.done   = c2h_status[xdma_pkg::STATUS_DONE_BIT];

endmodule

//--- hdl/dma_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// DMA control
// limits descriptors in flight per channel and returns requester credits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_ctrl (
  input  logic aclk,
  input  logic reset,
  dma_if.s     rd_q,
  dma_if.s     wr_q,
  dma_if.m     rd_eng,
  dma_if.m     wr_eng,
  output logic rd_credit,
  output logic wr_credit,
  output logic rd_done,
  output logic wr_done
);

  dma_pkg::cnt_t rd_out;  // read descriptors taken and not yet completed
  dma_pkg::cnt_t wr_out;  // write descriptors taken and not yet completed

  logic rd_room;  // read channel may hand over another descriptor
  logic wr_room;
  logic rd_pop;   // read queue head is taken this cycle
  logic wr_pop;

  // next in-flight level from a take and a completion in the same cycle
  function automatic dma_pkg::cnt_t next_out(dma_pkg::cnt_t cur, logic take, logic fin);
    dma_pkg::cnt_t nxt;
    nxt = cur;
    if (take && !fin) begin
      nxt = cur + 1'b1;
    end else if (fin && !take && cur != '0) begin
      nxt = cur - 1'b1;  // a stray done with nothing in flight is ignored
    end
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////////////////////

  assign rd_room = (rd_out < dma_pkg::cnt_t'(dma_pkg::MAX_OUTSTANDING));

  assign rd_eng.valid = rd_q.valid & rd_room;   // hold the head once the limit is hit
  assign rd_eng.paddr = rd_q.paddr;             // request fields go through untouched
  assign rd_eng.len   = rd_q.len;
  assign rd_eng.last  = rd_q.last;
  assign rd_q.ready   = rd_eng.ready & rd_room;
  assign rd_q.done    = rd_eng.done;            // the queue does not use it

  assign rd_pop  = rd_q.valid & rd_q.ready;
  assign rd_done = rd_eng.done;                 // completion straight to the requester

  ////////////////////////////////////////////////////////////////////////////
  // write channel
  ////////////////////////////////////////////////////////////////////////////

  assign wr_room = (wr_out < dma_pkg::cnt_t'(dma_pkg::MAX_OUTSTANDING));

  assign wr_eng.valid = wr_q.valid & wr_room;
  assign wr_eng.paddr = wr_q.paddr;
  assign wr_eng.len   = wr_q.len;
  assign wr_eng.last  = wr_q.last;
  assign wr_q.ready   = wr_eng.ready & wr_room;
  assign wr_q.done    = wr_eng.done;

  assign wr_pop  = wr_q.valid & wr_q.ready;
  assign wr_done = wr_eng.done;

  ////////////////////////////////////////////////////////////////////////////
  // in-flight counters and credit return
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (reset) begin
      rd_out    <= '0;
      wr_out    <= '0;
      rd_credit <= 1'b0;
      wr_credit <= 1'b0;
    end else begin
      rd_out    <= next_out(rd_out, rd_pop, rd_eng.done);
      wr_out    <= next_out(wr_out, wr_pop, wr_eng.done);
      rd_credit <= rd_pop;  // a freed queue slot becomes a credit one cycle later
      wr_credit <= wr_pop;
    end
  end

endmodule

//--- hdl/dma_req_queue.sv
////////////////////////////////////////////////////////////////////////////
// DMA request queue
// small FIFO holding credited requests until the control module drains them
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_req_queue (
  input  logic           aclk,
  input  logic           reset,
  input  logic           req_valid,
  input  dma_pkg::addr_t req_paddr,
  input  dma_pkg::len_t  req_len,
  input  logic           req_last,
  dma_if.m               q
);

  dma_pkg::addr_t paddr_mem [dma_pkg::QUEUE_DEPTH];  // address storage
  dma_pkg::len_t  len_mem   [dma_pkg::QUEUE_DEPTH];  // length storage
  logic           last_mem  [dma_pkg::QUEUE_DEPTH];  // last flag storage

  dma_pkg::ptr_t wr_ptr;  // next free slot
  dma_pkg::ptr_t rd_ptr;  // slot at the head
  dma_pkg::cnt_t count;   // entries currently held

  logic push;
  logic pop;

  // the requester only sends while it holds a credit so a push never meets a full queue
  assign push = req_valid;
  assign pop  = q.valid & q.ready;  // head leaves toward the engine

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (push) begin
      paddr_mem[wr_ptr] <= req_paddr;  // the tail slot takes the new request
      len_mem[wr_ptr]   <= req_len;
      last_mem[wr_ptr]  <= req_last;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers and fill count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // wrap at the last slot so depths that are not a power of two still work
        wr_ptr <= (wr_ptr == dma_pkg::ptr_t'(dma_pkg::QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == dma_pkg::ptr_t'(dma_pkg::QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;  // fill only
        2'b01:   count <= count - 1'b1;  // drain only
        default: count <= count;         // both or neither leave the level alone
      endcase
    end
  end

  // head is visible the cycle after it was written
  assign q.valid = (count != '0);
  assign q.paddr = paddr_mem[rd_ptr];
  assign q.len   = len_mem[rd_ptr];
  assign q.last  = last_mem[rd_ptr];

endmodule

//--- hdl/dma_if.sv
////////////////////////////////////////////////////////////////////////////
// DMA request channel
// valid/ready request with address, length and last flag plus a done strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface dma_if;

  logic           valid;  // request is presented
  logic           ready;  // receiver takes the request on this edge
  dma_pkg::addr_t paddr;  // physical address of the transfer
  dma_pkg::len_t  len;    // byte count
  logic           last;   // final descriptor of a transfer
  logic           done;   // one cycle completion strobe back toward the sender

  // request source side
  modport m (
    output valid,
    output paddr,
    output len,
    output last,
    input  ready,
    input  done
  );

  // request sink side
  modport s (
    input  valid,
    input  paddr,
    input  len,
    input  last,
    output ready,
    output done
  );

endinterface

//--- hdl/xdma_pkg.sv
////////////////////////////////////////////////////////////////////////////
// XDMA engine side definitions
// descriptor control word layout and status byte decoding
////////////////////////////////////////////////////////////////////////////

package xdma_pkg;

  typedef logic [15:0] ctl_t;    // descriptor bypass control word
  typedef logic [7:0]  status_t; // per channel engine status byte

  ////////////////////////////////////////////////////////////////////////////
  // control word bits
  ////////////////////////////////////////////////////////////////////////////

  // these three follow the last flag of the request and every other bit is zero
  localparam int CTL_STOP_BIT      = 0;  // engine stops after this descriptor
  localparam int CTL_COMPLETED_BIT = 1;  // engine reports completion of it
  localparam int CTL_EOP_BIT       = 4;  // descriptor closes the packet

  ////////////////////////////////////////////////////////////////////////////
  // status bits
  ////////////////////////////////////////////////////////////////////////////

  // pulses high for a single cycle each time a descriptor completes
  localparam int STATUS_DONE_BIT = 1;

endpackage

//--- hdl/dma_pkg.sv
////////////////////////////////////////////////////////////////////////////
// DMA request side definitions
// address and length types plus queue depth and in-flight limits
////////////////////////////////////////////////////////////////////////////

package dma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // request fields
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [63:0] addr_t;  // host physical address of a transfer
  typedef logic [27:0] len_t;   // transfer length in bytes

  ////////////////////////////////////////////////////////////////////////////
  // queueing and flow control
  ////////////////////////////////////////////////////////////////////////////

  // entries in each channel queue and also the credits a requester starts with
  localparam int QUEUE_DEPTH = 4;

  // descriptors that may sit at the engine per channel before flow stops
  localparam int MAX_OUTSTANDING = 2;

  // counts from zero up to QUEUE_DEPTH inclusive
  typedef logic [2:0] cnt_t;

  // index into a queue storage array
  typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;

endpackage
